// File: hdl/pipe_cpu_pkg.sv
// pipe_cpu_pkg: shared definitions for the five-stage pipelined processor
// Widths, instruction field positions, opcodes and ALU operations
package pipe_cpu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    // Instruction field positions
    localparam int op_hi     = 31;
    localparam int op_lo     = 27;
    localparam int rd_hi     = 26;
    localparam int rd_lo     = 22;
    localparam int rs_hi     = 21;
    localparam int rs_lo     = 17;
    localparam int rt_hi     = 16;
    localparam int rt_lo     = 12;
    localparam int shamt_hi  = 11;
    localparam int shamt_lo  = 7;
    localparam int aluop_hi  = 6;
    localparam int aluop_lo  = 2;
    localparam int imm_hi    = 16;
    localparam int imm_lo    = 0;
    localparam int target_hi = 26;
    localparam int target_lo = 0;

    typedef enum logic [4:0] {
        op_alu  = 5'd0,
        op_j    = 5'd1,
        op_bne  = 5'd2,
        op_jal  = 5'd3,
        op_jr   = 5'd4,
        op_addi = 5'd5,
        op_blt  = 5'd6,
        op_sw   = 5'd7,
        op_lw   = 5'd8
    } opcode_e;

    typedef enum logic [4:0] {
        alu_add = 5'd0,
        alu_sub = 5'd1,
        alu_and = 5'd2,
        alu_or  = 5'd3,
        alu_sll = 5'd4,
        alu_sra = 5'd5
    } alu_op_e;

    localparam reg_idx_t link_reg  = 5'd31;
    // add r0, r0, r0
    localparam word_t    nop_instr = '0;

    // Instructions that update the register file
    function automatic logic writes_reg(opcode_e op);
        return op inside {op_alu, op_addi, op_lw, op_jal};
    endfunction

    // Port B reads rd for these, rt otherwise
    function automatic logic reads_rd_on_b(opcode_e op);
        return op inside {op_sw, op_jr, op_bne, op_blt};
    endfunction

    // Destination register, jal always links into r31
    function automatic reg_idx_t dest_reg(word_t instr);
        if (opcode_e'(instr[op_hi:op_lo]) == op_jal) begin
            return link_reg;
        end
        return instr[rd_hi:rd_lo];
    endfunction

endpackage

// File: hdl/alu.sv
// alu: combinational integer ALU for the execute stage
// Add, sub, and, or and shifts, plus signed compare flags
`timescale 1ns/1ps

module alu (
    input  pipe_cpu_pkg::word_t   a,
    input  pipe_cpu_pkg::word_t   b,
    input  pipe_cpu_pkg::alu_op_e op,
    input  logic [4:0]            shamt,
    output pipe_cpu_pkg::word_t   result,
    output logic                  not_equal,
    output logic                  less_than
);

    always_comb begin
        case (op)
            pipe_cpu_pkg::alu_add: begin
                result = a + b;
            end
            pipe_cpu_pkg::alu_sub: begin
                result = a - b;
            end
            pipe_cpu_pkg::alu_and: begin
                result = a & b;
            end
            pipe_cpu_pkg::alu_or: begin
                result = a | b;
            end
            pipe_cpu_pkg::alu_sll: begin
                result = a << shamt;
            end
            pipe_cpu_pkg::alu_sra: begin
                result = $signed(a) >>> shamt;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Flags used by bne and blt
    assign not_equal = (a != b);
    assign less_than = ($signed(a) < $signed(b));

endmodule

// File: hdl/fetch_stage.sv
// fetch_stage: program counter and FD pipeline latch
// Advances the PC, takes redirects from execute and holds on load-use stalls
`timescale 1ns/1ps

module fetch_stage (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                stall,
    input  logic                flush,
    input  pipe_cpu_pkg::word_t redirect_pc,
    input  pipe_cpu_pkg::word_t q_imem,
    output pipe_cpu_pkg::word_t address_imem,
    output pipe_cpu_pkg::word_t fd_instr,
    output pipe_cpu_pkg::word_t fd_pc_next
);

    pipe_cpu_pkg::word_t pc;
    pipe_cpu_pkg::word_t pc_plus_one;

    assign pc_plus_one  = pc + pipe_cpu_pkg::word_t'(1);
    assign address_imem = pc;

    // Redirect wins over a stall
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (flush) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc_plus_one;
        end
    end

    // FD latch
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            fd_instr   <= pipe_cpu_pkg::nop_instr;
            fd_pc_next <= '0;
        end else if (flush) begin
            // Squash the word fetched on the wrong path
            fd_instr   <= pipe_cpu_pkg::nop_instr;
            fd_pc_next <= pc_plus_one;
        end else if (!stall) begin
            fd_instr   <= q_imem;
            fd_pc_next <= pc_plus_one;
        end
    end

endmodule

// File: hdl/decode_stage.sv
// decode_stage: register read, load-use hazard detection and the DX latch
// Inserts a bubble into DX on a stall or a redirect
`timescale 1ns/1ps

module decode_stage (
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic                   flush,
    input  pipe_cpu_pkg::word_t    fd_instr,
    input  pipe_cpu_pkg::word_t    fd_pc_next,
    input  pipe_cpu_pkg::word_t    data_read_reg_a,
    input  pipe_cpu_pkg::word_t    data_read_reg_b,
    output pipe_cpu_pkg::reg_idx_t ctrl_read_reg_a,
    output pipe_cpu_pkg::reg_idx_t ctrl_read_reg_b,
    output logic                   stall,
    output pipe_cpu_pkg::word_t    dx_instr,
    output pipe_cpu_pkg::word_t    dx_pc_next,
    output pipe_cpu_pkg::word_t    dx_a,
    output pipe_cpu_pkg::word_t    dx_b
);

    pipe_cpu_pkg::opcode_e  fd_op;
    pipe_cpu_pkg::opcode_e  dx_op;
    pipe_cpu_pkg::reg_idx_t dx_rd;

    assign fd_op = pipe_cpu_pkg::opcode_e'(fd_instr[pipe_cpu_pkg::op_hi:pipe_cpu_pkg::op_lo]);
    assign dx_op = pipe_cpu_pkg::opcode_e'(dx_instr[pipe_cpu_pkg::op_hi:pipe_cpu_pkg::op_lo]);
    assign dx_rd = dx_instr[pipe_cpu_pkg::rd_hi:pipe_cpu_pkg::rd_lo];

    // Register file addressing
    assign ctrl_read_reg_a = fd_instr[pipe_cpu_pkg::rs_hi:pipe_cpu_pkg::rs_lo];
    assign ctrl_read_reg_b = pipe_cpu_pkg::reads_rd_on_b(fd_op) ?
                             fd_instr[pipe_cpu_pkg::rd_hi:pipe_cpu_pkg::rd_lo] :
                             fd_instr[pipe_cpu_pkg::rt_hi:pipe_cpu_pkg::rt_lo];

    // Load in DX feeding the next instruction; sw store data is fixed up in mem
    assign stall = (dx_op == pipe_cpu_pkg::op_lw) && (dx_rd != '0) &&
                   ((dx_rd == ctrl_read_reg_a) ||
                    ((dx_rd == ctrl_read_reg_b) && (fd_op != pipe_cpu_pkg::op_sw)));

    // DX latch
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            dx_instr   <= pipe_cpu_pkg::nop_instr;
            dx_pc_next <= '0;
            dx_a       <= '0;
            dx_b       <= '0;
        end else begin
            dx_instr   <= (stall || flush) ? pipe_cpu_pkg::nop_instr : fd_instr;
            dx_pc_next <= fd_pc_next;
            dx_a       <= data_read_reg_a;
            dx_b       <= data_read_reg_b;
        end
    end

endmodule

// File: hdl/execute_stage.sv
// execute_stage: operand forwarding, ALU, branch and jump resolution
// Redirects fetch on taken control flow and fills the XM latch
`timescale 1ns/1ps

module execute_stage (
    input  logic                   clock,
    input  logic                   arst_n,
    input  pipe_cpu_pkg::word_t    dx_instr,
    input  pipe_cpu_pkg::word_t    dx_pc_next,
    input  pipe_cpu_pkg::word_t    dx_a,
    input  pipe_cpu_pkg::word_t    dx_b,
    input  pipe_cpu_pkg::reg_idx_t mw_rd,
    input  logic                   mw_write,
    input  pipe_cpu_pkg::word_t    data_write_reg,
    output logic                   flush,
    output pipe_cpu_pkg::word_t    redirect_pc,
    output pipe_cpu_pkg::word_t    xm_instr,
    output pipe_cpu_pkg::word_t    xm_result,
    output pipe_cpu_pkg::word_t    xm_store,
    output pipe_cpu_pkg::word_t    xm_pc_next
);

    pipe_cpu_pkg::opcode_e  dx_op;
    pipe_cpu_pkg::opcode_e  xm_op;
    pipe_cpu_pkg::alu_op_e  alu_op;
    pipe_cpu_pkg::reg_idx_t b_src;
    pipe_cpu_pkg::reg_idx_t xm_dest;
    pipe_cpu_pkg::word_t    imm_sext;
    pipe_cpu_pkg::word_t    jump_target;
    pipe_cpu_pkg::word_t    op_a;
    pipe_cpu_pkg::word_t    op_b;
    pipe_cpu_pkg::word_t    alu_b;
    pipe_cpu_pkg::word_t    alu_result;
    logic                   xm_write;
    logic                   use_imm;
    logic                   not_equal;
    logic                   less_than;
    logic                   branch_taken;
    logic                   jump;

    // Newest producer first, r0 never forwards
    function automatic pipe_cpu_pkg::word_t forward(pipe_cpu_pkg::reg_idx_t src,
                                                    pipe_cpu_pkg::word_t    rf_val);
        if (src == '0) begin
            return rf_val;
        end
        if (xm_write && (xm_dest == src)) begin
            return xm_result;
        end
        if (mw_write && (mw_rd == src)) begin
            return data_write_reg;
        end
        return rf_val;
    endfunction

    assign dx_op = pipe_cpu_pkg::opcode_e'(dx_instr[pipe_cpu_pkg::op_hi:pipe_cpu_pkg::op_lo]);
    assign xm_op = pipe_cpu_pkg::opcode_e'(xm_instr[pipe_cpu_pkg::op_hi:pipe_cpu_pkg::op_lo]);

    assign xm_dest  = pipe_cpu_pkg::dest_reg(xm_instr);
    assign xm_write = pipe_cpu_pkg::writes_reg(xm_op);

    assign b_src = pipe_cpu_pkg::reads_rd_on_b(dx_op) ?
                   dx_instr[pipe_cpu_pkg::rd_hi:pipe_cpu_pkg::rd_lo] :
                   dx_instr[pipe_cpu_pkg::rt_hi:pipe_cpu_pkg::rt_lo];

    always_comb begin
        op_a = forward(dx_instr[pipe_cpu_pkg::rs_hi:pipe_cpu_pkg::rs_lo], dx_a);
        op_b = forward(b_src, dx_b);
    end

    assign imm_sext = {{(pipe_cpu_pkg::xlen - pipe_cpu_pkg::imm_hi + pipe_cpu_pkg::imm_lo - 1)
                        {dx_instr[pipe_cpu_pkg::imm_hi]}},
                       dx_instr[pipe_cpu_pkg::imm_hi:pipe_cpu_pkg::imm_lo]};
    assign jump_target = {{(pipe_cpu_pkg::xlen - pipe_cpu_pkg::target_hi
                            + pipe_cpu_pkg::target_lo - 1){1'b0}},
                          dx_instr[pipe_cpu_pkg::target_hi:pipe_cpu_pkg::target_lo]};

    assign use_imm = dx_op inside {pipe_cpu_pkg::op_addi, pipe_cpu_pkg::op_lw,
                                   pipe_cpu_pkg::op_sw};
    assign alu_b   = use_imm ? imm_sext : op_b;

    always_comb begin
        case (dx_op)
            pipe_cpu_pkg::op_alu: begin
                alu_op = pipe_cpu_pkg::alu_op_e'(
                    dx_instr[pipe_cpu_pkg::aluop_hi:pipe_cpu_pkg::aluop_lo]);
            end
            pipe_cpu_pkg::op_bne, pipe_cpu_pkg::op_blt: begin
                alu_op = pipe_cpu_pkg::alu_sub;
            end
            default: begin
                alu_op = pipe_cpu_pkg::alu_add;
            end
        endcase
    end

    alu alu_inst (
        .a         (op_a),
        .b         (alu_b),
        .op        (alu_op),
        .shamt     (dx_instr[pipe_cpu_pkg::shamt_hi:pipe_cpu_pkg::shamt_lo]),
        .result    (alu_result),
        .not_equal (not_equal),
        .less_than (less_than)
    );

    // blt compares rd < rs, with rs on the A side
    assign branch_taken = ((dx_op == pipe_cpu_pkg::op_bne) && not_equal) ||
                          ((dx_op == pipe_cpu_pkg::op_blt) && not_equal && !less_than);
    assign jump  = dx_op inside {pipe_cpu_pkg::op_j, pipe_cpu_pkg::op_jal, pipe_cpu_pkg::op_jr};
    assign flush = branch_taken || jump;

    always_comb begin
        if (dx_op == pipe_cpu_pkg::op_jr) begin
            redirect_pc = op_b;
        end else if (jump) begin
            redirect_pc = jump_target;
        end else begin
            redirect_pc = dx_pc_next + imm_sext;
        end
    end

    // XM latch
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            xm_instr   <= pipe_cpu_pkg::nop_instr;
            xm_result  <= '0;
            xm_store   <= '0;
            xm_pc_next <= '0;
        end else begin
            xm_instr   <= dx_instr;
            xm_result  <= (dx_op == pipe_cpu_pkg::op_jal) ? dx_pc_next : alu_result;
            xm_store   <= op_b;
            xm_pc_next <= dx_pc_next;
        end
    end

endmodule

// File: hdl/mem_wb_stage.sv
// mem_wb_stage: data memory access, MW latch and register writeback
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic                   clock,
    input  logic                   arst_n,
    input  pipe_cpu_pkg::word_t    xm_instr,
    input  pipe_cpu_pkg::word_t    xm_result,
    input  pipe_cpu_pkg::word_t    xm_store,
    input  pipe_cpu_pkg::word_t    q_dmem,
    output pipe_cpu_pkg::word_t    address_dmem,
    output pipe_cpu_pkg::word_t    data,
    output logic                   wren,
    output logic                   ctrl_write_enable,
    output pipe_cpu_pkg::reg_idx_t ctrl_write_reg,
    output pipe_cpu_pkg::word_t    data_write_reg,
    output pipe_cpu_pkg::reg_idx_t mw_rd,
    output logic                   mw_write
);

    pipe_cpu_pkg::opcode_e xm_op;
    pipe_cpu_pkg::opcode_e mw_op;
    pipe_cpu_pkg::word_t   mw_instr;
    pipe_cpu_pkg::word_t   mw_result;
    pipe_cpu_pkg::word_t   mw_load;

    assign xm_op = pipe_cpu_pkg::opcode_e'(xm_instr[pipe_cpu_pkg::op_hi:pipe_cpu_pkg::op_lo]);
    assign mw_op = pipe_cpu_pkg::opcode_e'(mw_instr[pipe_cpu_pkg::op_hi:pipe_cpu_pkg::op_lo]);

    assign address_dmem = xm_result;
    assign wren         = (xm_op == pipe_cpu_pkg::op_sw);
    // Store data from the instruction just ahead, covers a lw right before sw
    assign data = (mw_write && (mw_rd == xm_instr[pipe_cpu_pkg::rd_hi:pipe_cpu_pkg::rd_lo])) ?
                  data_write_reg : xm_store;

    // MW latch
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mw_instr  <= pipe_cpu_pkg::nop_instr;
            mw_result <= '0;
            mw_load   <= '0;
        end else begin
            mw_instr  <= xm_instr;
            mw_result <= xm_result;
            mw_load   <= q_dmem;
        end
    end

    // Writes to r0 are dropped so bubbles never touch the register file
    assign mw_rd    = pipe_cpu_pkg::dest_reg(mw_instr);
    assign mw_write = pipe_cpu_pkg::writes_reg(mw_op) && (mw_rd != '0);

    assign ctrl_write_enable = mw_write;
    assign ctrl_write_reg    = mw_rd;
    assign data_write_reg    = (mw_op == pipe_cpu_pkg::op_lw) ? mw_load : mw_result;

endmodule

// File: hdl/pipe_cpu.sv
// pipe_cpu: five-stage pipelined integer processor core
// Memories and register file sit outside and are reached through loose ports
`timescale 1ns/1ps

module pipe_cpu (
    input  logic                   clock,
    input  logic                   arst_n,
    // Instruction memory
    output pipe_cpu_pkg::word_t    address_imem,
    input  pipe_cpu_pkg::word_t    q_imem,
    // Data memory
    output pipe_cpu_pkg::word_t    address_dmem,
    output pipe_cpu_pkg::word_t    data,
    output logic                   wren,
    input  pipe_cpu_pkg::word_t    q_dmem,
    // Register file
    output logic                   ctrl_write_enable,
    output pipe_cpu_pkg::reg_idx_t ctrl_write_reg,
    output pipe_cpu_pkg::reg_idx_t ctrl_read_reg_a,
    output pipe_cpu_pkg::reg_idx_t ctrl_read_reg_b,
    output pipe_cpu_pkg::word_t    data_write_reg,
    input  pipe_cpu_pkg::word_t    data_read_reg_a,
    input  pipe_cpu_pkg::word_t    data_read_reg_b
);

    logic                   stall;
    logic                   flush;
    pipe_cpu_pkg::word_t    redirect_pc;
    pipe_cpu_pkg::word_t    fd_instr;
    pipe_cpu_pkg::word_t    fd_pc_next;
    pipe_cpu_pkg::word_t    dx_instr;
    pipe_cpu_pkg::word_t    dx_pc_next;
    pipe_cpu_pkg::word_t    dx_a;
    pipe_cpu_pkg::word_t    dx_b;
    pipe_cpu_pkg::word_t    xm_instr;
    pipe_cpu_pkg::word_t    xm_result;
    pipe_cpu_pkg::word_t    xm_store;
    pipe_cpu_pkg::reg_idx_t mw_rd;
    logic                   mw_write;

    fetch_stage fetch_inst (
        .clock        (clock),
        .arst_n       (arst_n),
        .stall        (stall),
        .flush        (flush),
        .redirect_pc  (redirect_pc),
        .q_imem       (q_imem),
        .address_imem (address_imem),
        .fd_instr     (fd_instr),
        .fd_pc_next   (fd_pc_next)
    );

    decode_stage decode_inst (
        .clock           (clock),
        .arst_n          (arst_n),
        .flush           (flush),
        .fd_instr        (fd_instr),
        .fd_pc_next      (fd_pc_next),
        .data_read_reg_a (data_read_reg_a),
        .data_read_reg_b (data_read_reg_b),
        .ctrl_read_reg_a (ctrl_read_reg_a),
        .ctrl_read_reg_b (ctrl_read_reg_b),
        .stall           (stall),
        .dx_instr        (dx_instr),
        .dx_pc_next      (dx_pc_next),
        .dx_a            (dx_a),
        .dx_b            (dx_b)
    );

    // The XM copy of PC+1 is not needed downstream, jal already carries it
    execute_stage execute_inst (
        .clock          (clock),
        .arst_n         (arst_n),
        .dx_instr       (dx_instr),
        .dx_pc_next     (dx_pc_next),
        .dx_a           (dx_a),
        .dx_b           (dx_b),
        .mw_rd          (mw_rd),
        .mw_write       (mw_write),
        .data_write_reg (data_write_reg),
        .flush          (flush),
        .redirect_pc    (redirect_pc),
        .xm_instr       (xm_instr),
        .xm_result      (xm_result),
        .xm_store       (xm_store),
        .xm_pc_next     ()
    );

    mem_wb_stage mem_wb_inst (
        .clock             (clock),
        .arst_n            (arst_n),
        .xm_instr          (xm_instr),
        .xm_result         (xm_result),
        .xm_store          (xm_store),
        .q_dmem            (q_dmem),
        .address_dmem      (address_dmem),
        .data              (data),
        .wren              (wren),
        .ctrl_write_enable (ctrl_write_enable),
        .ctrl_write_reg    (ctrl_write_reg),
        .data_write_reg    (data_write_reg),
        .mw_rd             (mw_rd),
        .mw_write          (mw_write)
    );

endmodule

// File: sim/tb_clock_gen.sv
// tb_clock_gen: free-running testbench clock
// 8 ns period, starts low
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock
);

    initial begin
        clock = 1'b0;
    end

    always #4 clock = ~clock;

endmodule

// File: sim/tb_pipe_cpu.sv
// tb_pipe_cpu: testbench for the pipelined processor
// Models memories and register file, runs a random program against an in-order model
`timescale 1ns/1ps

module tb_pipe_cpu;

    localparam int prog_len = 200;
    localparam int last_pc  = prog_len - 1;

    logic clock;
    logic arst_n;
    logic [31:0] address_imem, q_imem, address_dmem, data, q_dmem, data_write_reg;
    logic [31:0] data_read_reg_a, data_read_reg_b;
    logic [4:0]  ctrl_write_reg, ctrl_read_reg_a, ctrl_read_reg_b;
    logic        wren, ctrl_write_enable;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] regs [0:31];
    logic [31:0] model_mem [0:255];
    logic [31:0] model_regs [0:31];
    logic [36:0] dut_reg_q[$], model_reg_q[$];
    logic [39:0] dut_mem_q[$], model_mem_q[$];
    logic [31:0] lfsr_state;
    int          error_count;

    tb_clock_gen clock_gen_inst (.clock(clock));

    pipe_cpu pipe_cpu_inst (
        .clock(clock), .arst_n(arst_n),
        .address_imem(address_imem), .q_imem(q_imem),
        .address_dmem(address_dmem), .data(data), .wren(wren), .q_dmem(q_dmem),
        .ctrl_write_enable(ctrl_write_enable), .ctrl_write_reg(ctrl_write_reg),
        .ctrl_read_reg_a(ctrl_read_reg_a), .ctrl_read_reg_b(ctrl_read_reg_b),
        .data_write_reg(data_write_reg),
        .data_read_reg_a(data_read_reg_a), .data_read_reg_b(data_read_reg_b)
    );

    // Memories answer in the same cycle, register file reads through a same-cycle write
    assign q_imem = imem[address_imem[7:0]];
    assign q_dmem = dmem[address_dmem[7:0]];
    assign data_read_reg_a = (ctrl_write_enable && ctrl_write_reg == ctrl_read_reg_a &&
                              ctrl_read_reg_a != 5'd0) ? data_write_reg : regs[ctrl_read_reg_a];
    assign data_read_reg_b = (ctrl_write_enable && ctrl_write_reg == ctrl_read_reg_b &&
                              ctrl_read_reg_b != 5'd0) ? data_write_reg : regs[ctrl_read_reg_b];

    always @(posedge clock) begin
        if (wren) begin
            dmem[address_dmem[7:0]] <= data;
        end
        if (ctrl_write_enable && ctrl_write_reg != 5'd0) begin
            regs[ctrl_write_reg] <= data_write_reg;
        end
    end

    // Write streams seen at the DUT ports, sampled mid-cycle
    always @(negedge clock) begin
        if (arst_n && ctrl_write_enable) begin
            dut_reg_q.push_back({ctrl_write_reg, data_write_reg});
        end
        if (arst_n && wren) begin
            dut_mem_q.push_back({address_dmem[7:0], data});
        end
    end

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        logic lsb;
        lsb = s[0];
        s = s >> 1;
        if (lsb) begin
            s = s ^ 32'h80200003;
        end
        return s;
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            val[k] = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
        return val;
    endfunction

    function automatic logic [31:0] encode(logic [4:0] op, logic [4:0] rd, logic [4:0] rs,
                                           logic [16:0] low);
        logic [31:0] w;
        w = '0;
        w[pipe_cpu_pkg::op_hi:pipe_cpu_pkg::op_lo] = op;
        w[pipe_cpu_pkg::rd_hi:pipe_cpu_pkg::rd_lo] = rd;
        w[pipe_cpu_pkg::rs_hi:pipe_cpu_pkg::rs_lo] = rs;
        w[pipe_cpu_pkg::imm_hi:pipe_cpu_pkg::imm_lo] = low;
        return w;
    endfunction

    function automatic logic [31:0] sext17(logic [16:0] v);
        return {{15{v[16]}}, v};
    endfunction

    task automatic check(string what, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // Forward-only control flow, so the program always reaches its final self-jump
    task automatic build_program;
        int i;
        int kind;
        int tgt;
        logic [4:0] rd, rs;
        logic [255:0] is_target;
        i = 0;
        is_target = '0;
        while (i < last_pc) begin
            kind = int'(take_bits(4));
            rd = take_bits(3);
            rs = take_bits(3);
            tgt = i + 1 + int'(take_bits(3));
            if (tgt > last_pc) begin
                tgt = last_pc;
            end
            if (kind <= 4) begin
                imem[i] = encode(pipe_cpu_pkg::op_alu, rd, rs,
                                 {5'(take_bits(3)), 5'(take_bits(5)),
                                  5'(take_bits(3) % 6), 2'b00});
            end else if (kind <= 7) begin
                imem[i] = encode(pipe_cpu_pkg::op_addi, rd, rs, take_bits(17));
            end else if (kind <= 9) begin
                imem[i] = encode(pipe_cpu_pkg::op_lw, rd, 5'd0, {9'd0, 8'(take_bits(8))});
            end else if (kind <= 11) begin
                imem[i] = encode(pipe_cpu_pkg::op_sw, rd, 5'd0, {9'd0, 8'(take_bits(8))});
            end else if (kind <= 13) begin
                imem[i] = encode(kind == 12 ? pipe_cpu_pkg::op_bne : pipe_cpu_pkg::op_blt,
                                 rd, rs, 17'(tgt - i - 1));
                is_target[tgt] = 1'b1;
            end else if (kind == 14) begin
                imem[i] = {take_bits(1) ? pipe_cpu_pkg::op_jal : pipe_cpu_pkg::op_j, 27'(tgt)};
                is_target[tgt] = 1'b1;
            end else if (i + 2 < last_pc && !is_target[i + 1]) begin
                // Address loaded right before jr, so jr needs the forwarded value
                // No earlier branch may land on the jr and skip its address load
                if (tgt < i + 2) begin
                    tgt = i + 2;
                end
                is_target[tgt] = 1'b1;
                rd = (rd == 5'd0) ? 5'd7 : rd;
                imem[i] = encode(pipe_cpu_pkg::op_addi, rd, 5'd0, 17'(tgt));
                i++;
                imem[i] = encode(pipe_cpu_pkg::op_jr, rd, 5'd0, 17'd0);
            end
            i++;
        end
        imem[last_pc] = {pipe_cpu_pkg::op_j, 27'(last_pc)};
    endtask

    task automatic model_write(logic [4:0] idx, logic [31:0] val);
        if (idx != 5'd0) begin
            model_regs[idx] = val;
            model_reg_q.push_back({idx, val});
        end
    endtask

    task automatic run_model;
        int pc;
        int next_pc;
        int steps;
        logic [31:0] ins, a, b, t, addr;
        logic [4:0]  op, rd, rs, rt, sh;
        pc = 0;
        steps = 0;
        while (pc != last_pc && steps < 2000) begin
            ins = imem[pc];
            op = ins[31:27];
            rd = ins[26:22];
            rs = ins[21:17];
            rt = ins[16:12];
            sh = ins[11:7];
            a = model_regs[rs];
            b = model_regs[rt];
            t = model_regs[rd];
            addr = a + sext17(ins[16:0]);
            next_pc = pc + 1;
            case (op)
                pipe_cpu_pkg::op_alu: begin
                    case (ins[6:2])
                        pipe_cpu_pkg::alu_add: model_write(rd, a + b);
                        pipe_cpu_pkg::alu_sub: model_write(rd, a - b);
                        pipe_cpu_pkg::alu_and: model_write(rd, a & b);
                        pipe_cpu_pkg::alu_or:  model_write(rd, a | b);
                        pipe_cpu_pkg::alu_sll: model_write(rd, a << sh);
                        default:               model_write(rd, $signed(a) >>> sh);
                    endcase
                end
                pipe_cpu_pkg::op_addi: model_write(rd, addr);
                pipe_cpu_pkg::op_lw:   model_write(rd, model_mem[addr[7:0]]);
                pipe_cpu_pkg::op_sw: begin
                    model_mem[addr[7:0]] = t;
                    model_mem_q.push_back({addr[7:0], t});
                end
                pipe_cpu_pkg::op_bne: begin
                    if (t != a) next_pc = pc + 1 + int'(sext17(ins[16:0]));
                end
                // blt is taken when rd is less than rs
                pipe_cpu_pkg::op_blt: begin
                    if ($signed(t) < $signed(a)) next_pc = pc + 1 + int'(sext17(ins[16:0]));
                end
                pipe_cpu_pkg::op_jal: begin
                    model_write(pipe_cpu_pkg::link_reg, 32'(pc + 1));
                    next_pc = int'(ins[26:0]);
                end
                pipe_cpu_pkg::op_j:  next_pc = int'(ins[26:0]);
                default:             next_pc = int'(t);
            endcase
            pc = next_pc;
            steps++;
        end
        if (pc != last_pc) begin
            $display("Reference model did not reach the final instruction");
            error_count++;
        end
    endtask

    initial begin
        int cycles;
        arst_n = 1'b0;
        error_count = 0;
        lfsr_state = 32'd74584;
        for (int k = 0; k < 256; k++) begin
            imem[k] = pipe_cpu_pkg::nop_instr;
            dmem[k] = (k * 32'h9e3779b1) ^ 32'h00c0ffee;
            model_mem[k] = dmem[k];
        end
        for (int k = 0; k < 32; k++) begin
            regs[k] = '0;
            model_regs[k] = '0;
        end
        build_program();
        run_model();
        // Bus writes must stay quiet through reset and until the first instruction lands
        for (int k = 0; k < 18; k++) begin
            @(negedge clock);
            arst_n = (k >= 15);
            check("wren idle", wren, 0);
            check("write enable idle", ctrl_write_enable, 0);
        end
        cycles = 0;
        while (address_imem != last_pc && cycles < 5000) begin
            @(negedge clock);
            cycles++;
        end
        if (address_imem != last_pc) begin
            $display("Timeout: the DUT never fetched the final instruction");
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            repeat (5) @(negedge clock);
            check("register write count", dut_reg_q.size(), model_reg_q.size());
            check("memory write count", dut_mem_q.size(), model_mem_q.size());
            for (int k = 0; k < dut_reg_q.size() && k < model_reg_q.size(); k++) begin
                check("register write", dut_reg_q[k], model_reg_q[k]);
            end
            for (int k = 0; k < dut_mem_q.size() && k < model_mem_q.size(); k++) begin
                check("memory write", dut_mem_q[k], model_mem_q[k]);
            end
            for (int k = 0; k < 32; k++) begin
                check($sformatf("final r%0d", k), regs[k], model_regs[k]);
            end
            for (int k = 0; k < 256; k++) begin
                check($sformatf("final mem[%0d]", k), dmem[k], model_mem[k]);
            end
            $display("Checked %0d register and %0d memory writes, %0d errors",
                     model_reg_q.size(), model_mem_q.size(), error_count);
            if (error_count == 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule

// File: pipe_cpu.f
hdl/pipe_cpu_pkg.sv
hdl/alu.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/pipe_cpu.sv
sim/tb_clock_gen.sv
sim/tb_pipe_cpu.sv

// File: Makefile
# Verilator build and run for the pipe_cpu testbench

VERILATOR ?= verilator
TOP       ?= tb_pipe_cpu
FILELIST  ?= pipe_cpu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
